//--- Makefile
# Verilator build and run of the auto-zero front end testbench.

VERILATOR  ?= verilator
TOP        ?= tb_az_frontend
RTL_TOP    ?= az_frontend_top
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= -Wall
RTL_SRCS   ?= rtl/az_pkg.sv rtl/az_regs.sv rtl/modulation_az.sv rtl/az_frontend_top.sv
PASS_TEXT  ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_az_frontend.sv
// testbench for the auto-zero front end with register tasks, output tracker, assertions and watchdog.
`timescale 1ns/1ps

module tb_az_frontend;
  import az_pkg::*;

  // small reset defaults keep the phases short in simulation.
  localparam int init_sample    = 6;
  localparam int init_precharge = 3;

  // longest loop with durations of at most 12, and the cycle budget of the whole run.
  localparam int max_dur         = 12;
  localparam int loop_cycles     = 3 * (max_dur + 2) + 2 * (max_dur + 2) + 1;
  localparam int planned_loops   = 18;
  localparam int watchdog_cycles = planned_loops * loop_cycles + 300;

  logic                  clk;
  logic                  reset;
  logic                  reg_wr;
  logic [reg_addr_w-1:0] reg_addr;
  logic [reg_data_w-1:0] reg_wdata;
  logic [reg_data_w-1:0] reg_rdata;
  logic                  sw_pc_ctl;
  logic [azmux_w-1:0]    azmux;
  logic                  led0;
  logic [monitor_w-1:0]  monitor;
  logic                  sample_valid;
  logic                  sample_phase;

  // expected register contents, built from the register map.
  logic                   m_run;
  logic [azmux_w-1:0]     m_lo;
  logic [azmux_w-1:0]     m_hi;
  logic [duration_w-1:0]  m_sample;
  logic [precharge_w-1:0] m_precharge;

  // output tracker state.
  int   cyc = 0;
  int   step;
  int   last_cyc;
  int   exp_gap;
  int   next_gap;
  int   pulse_cyc;
  int   pulses0;
  int   pulses1;
  bit   have_last;
  bit   halted;
  bit   from_lo;
  bit   pulse_seen;
  bit   pc_chg;
  bit   mux_chg;
  logic prev_pc;
  logic [azmux_w-1:0] prev_mux;
  logic prev_run;

  int error_count;
  int check_count;
  int seed;
  logic [reg_data_w-1:0] w;
  int hi_code;
  int lo_code;

  az_frontend_top #(
    .default_sample    (32'd6),
    .default_precharge (24'd3)
  ) DUT (
    .clk          (clk),
    .reset        (reset),
    .reg_wr       (reg_wr),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .reg_rdata    (reg_rdata),
    .sw_pc_ctl    (sw_pc_ctl),
    .azmux        (azmux),
    .led0         (led0),
    .monitor      (monitor),
    .sample_valid (sample_valid),
    .sample_phase (sample_phase)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // edge counter, so the tracker can measure phase lengths in cycles.
  always @(posedge clk)
    cyc <= cyc + 1;

  task automatic note_failure(input string msg);
    error_count++;
    $display("failure at %0t: %s.", $time, msg);
  endtask

  task automatic check_value(input string name, input longint expected, input longint actual);
    check_count++;
    assert (actual == expected)
    else
    begin
      error_count++;
      $display("error at %0t: %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
    end
  endtask

  //////////////////////////////
  // host register tasks.
  //////////////////////////////

  // both tasks start and end on a falling edge.
  task automatic reg_write(input logic [reg_addr_w-1:0] addr, input logic [reg_data_w-1:0] data);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_wr = 1'b0;
  endtask

  task automatic reg_read_check(input logic [reg_addr_w-1:0] addr,
                                input logic [reg_data_w-1:0] expected, input string name);
    reg_addr = addr;
    @(negedge clk);
    check_value(name, expected, reg_rdata);
  endtask

  // waits for n new sample strobes of one phase, bounded by the loop length.
  task automatic wait_pulses(input bit phase, input int n);
    int target;
    int waited;
    @(posedge clk);
    target = (phase ? pulses1 : pulses0) + n;
    waited = 0;
    while (((phase ? pulses1 : pulses0) < target) && (waited < (n + 1) * loop_cycles))
    begin
      @(posedge clk);
      waited++;
    end
    assert ((phase ? pulses1 : pulses0) >= target)
    else note_failure("sample strobe did not arrive within the expected loop time");
    @(negedge clk);
  endtask

  // stop after the next signal sample, then confirm the loop finished and holds still.
  task automatic stop_and_hold();
    wait_pulses(1'b1, 1);
    reg_write(reg_ctrl, 32'd0);
    wait_pulses(1'b0, 1);
    repeat (2 * loop_cycles) @(negedge clk);
    check_value("halted", 1, halted);
    check_value("sw_pc_ctl", sw_pc_boot, sw_pc_ctl);
    reg_read_check(reg_ctrl, 32'd0, "reg_ctrl");
    reg_read_check(reg_cycles, pulses0, "reg_cycles");
  endtask

  //////////////////////////////
  // register model.
  //////////////////////////////

  always @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      m_run       <= 1'b0;
      m_lo        <= '0;
      m_hi        <= '0;
      m_sample    <= init_sample;
      m_precharge <= init_precharge;
    end
    else if (reg_wr)
    begin
      if (reg_addr == reg_ctrl)
        m_run <= reg_wdata[0];
      if (reg_addr == reg_azmux)
      begin
        m_lo <= reg_wdata[3:0];
        m_hi <= reg_wdata[7:4];
      end
      if (reg_addr == reg_sample)
        m_sample <= reg_wdata;
      if (reg_addr == reg_precharge)
        m_precharge <= reg_wdata[23:0];
    end
  end

  //////////////////////////////
  // output tracker.
  //////////////////////////////

  // steps of the loop: 0 waits for azmux hi, 1 for pc signal, 2 for pc boot, 3 for azmux lo.
  always @(negedge clk)
  begin
    if (reset)
    begin
      step       = 0;
      halted     = 1'b1;
      have_last  = 1'b0;
      from_lo    = 1'b0;
      pulse_seen = 1'b0;
      pulses0    = 0;
      pulses1    = 0;
      prev_pc    = sw_pc_boot;
      prev_mux   = '0;
      prev_run   = 1'b0;
    end
    else
    begin
      pc_chg  = (sw_pc_ctl !== prev_pc);
      mux_chg = (azmux !== prev_mux);
      if (sample_valid)
      begin
        assert (!pulse_seen) else note_failure("two sample strobes in one sample phase");
        if (sample_phase)
        begin
          assert (step == 2) else note_failure("signal sample strobe outside the signal phase");
          pulses1++;
        end
        else
        begin
          assert ((step == 0) && from_lo) else note_failure("zero sample strobe outside the lo phase");
          pulses0++;
          // with run low the loop ends here and the outputs must then hold.
          if (!m_run)
            halted = 1'b1;
        end
        pulse_seen = 1'b1;
        pulse_cyc  = cyc;
      end
      // a restart enters pc_boot_entry on the edge after run is seen high.
      if (m_run && !prev_run && halted)
      begin
        halted     = 1'b0;
        from_lo    = 1'b0;
        pulse_seen = 1'b0;
        have_last  = 1'b1;
        last_cyc   = cyc + 1;
        exp_gap    = m_precharge + 2;
      end
      if (halted)
      begin
        assert (!pc_chg && !mux_chg) else note_failure("outputs changed while stopped");
        check_value("sw_pc_ctl", sw_pc_boot, sw_pc_ctl);
      end
      else if (pc_chg || mux_chg)
      begin
        assert (!(pc_chg && mux_chg)) else note_failure("pc switch and azmux moved together");
        next_gap = 0;
        case (step)
          0:
          begin
            assert (mux_chg && (azmux == m_hi)) else note_failure("expected azmux to move to hi");
            if (from_lo)
            begin
              assert (pulse_seen) else note_failure("no zero sample strobe in the lo phase");
              check_value("zero strobe cycle", cyc - 2, pulse_cyc);
            end
            next_gap = m_precharge + 2;
          end
          1:
          begin
            assert (pc_chg && (sw_pc_ctl == sw_pc_signal))
            else note_failure("expected pc switch to move to signal");
            next_gap = m_sample + 2;
          end
          2:
          begin
            assert (pc_chg && (sw_pc_ctl == sw_pc_boot))
            else note_failure("expected pc switch to move back to boot");
            assert (pulse_seen) else note_failure("no signal sample strobe in the signal phase");
            check_value("signal strobe cycle", cyc - 1, pulse_cyc);
            next_gap = m_precharge + 2;
          end
          default:
          begin
            assert (mux_chg && (azmux == m_lo)) else note_failure("expected azmux to move to lo");
            // the lo phase also covers the loop_end cycle.
            next_gap = m_sample + 3;
          end
        endcase
        if (have_last)
          check_value("phase length", exp_gap, cyc - last_cyc);
        from_lo    = (step == 3);
        pulse_seen = 1'b0;
        exp_gap    = next_gap;
        last_cyc   = cyc;
        have_last  = 1'b1;
        step       = (step + 1) % 4;
      end
      assert (!((sw_pc_ctl == sw_pc_signal) && (azmux == m_lo)))
      else note_failure("pc switch at signal while azmux holds the lo code");
      check_value("monitor[0]", step != 0, monitor[0]);
    end
    prev_pc  = sw_pc_ctl;
    prev_mux = azmux;
    prev_run = m_run;
  end

  // led and monitor patterns follow the switch outputs.
  a_led_sig : assert property (@(posedge clk) disable iff (reset)
    led0 == (sw_pc_ctl == sw_pc_signal))
    else note_failure("led0 does not follow the signal sample");
  a_mon_sig : assert property (@(posedge clk) disable iff (reset) monitor[1] == led0)
    else note_failure("monitor bit 1 does not follow the signal sample");
  a_mon_zero : assert property (@(posedge clk) disable iff (reset) monitor[7:3] == 5'd0)
    else note_failure("unused monitor bits are not zero");
  a_strobe_once : assert property (@(posedge clk) disable iff (reset)
    sample_valid |=> !sample_valid)
    else note_failure("sample strobe longer than one cycle");
  a_done_after : assert property (@(posedge clk) disable iff (reset)
    (sample_valid && !sample_phase) |=> monitor[2])
    else note_failure("no cycle done pulse after the zero sample");
  a_done_once : assert property (@(posedge clk) disable iff (reset) monitor[2] |=> !monitor[2])
    else note_failure("cycle done pulse longer than one cycle");

  initial
  begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles.", watchdog_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  //////////////////////////////
  // stimulus.
  //////////////////////////////

  initial
  begin
    reset       = 1'b1;
    reg_wr      = 1'b0;
    reg_addr    = '0;
    reg_wdata   = '0;
    error_count = 0;
    check_count = 0;
    seed        = 57;
    void'($urandom(seed));
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // reset state and defaults, then idle with run low.
    check_value("sw_pc_ctl", sw_pc_boot, sw_pc_ctl);
    check_value("azmux", 0, azmux);
    check_value("led0", 0, led0);
    check_value("monitor", 0, monitor);
    check_value("sample_valid", 0, sample_valid);
    reg_read_check(reg_ctrl, 32'd0, "reg_ctrl");
    reg_read_check(reg_sample, init_sample, "reg_sample");
    reg_read_check(reg_precharge, init_precharge, "reg_precharge");
    reg_read_check(reg_cycles, 32'd0, "reg_cycles");
    repeat (20) @(negedge clk);

    // register file readback, unmapped addresses and the read-only count.
    w = $urandom;
    reg_write(reg_azmux, w);
    reg_read_check(reg_azmux, w & 32'hff, "reg_azmux");
    w = $urandom;
    reg_write(reg_sample, w);
    reg_read_check(reg_sample, w, "reg_sample");
    w = $urandom;
    reg_write(reg_precharge, w);
    reg_read_check(reg_precharge, w & 32'hff_ffff, "reg_precharge");
    for (int a = 5; a < 8; a++)
    begin
      reg_write(a, $urandom);
      reg_read_check(a, 32'd0, "unused address");
    end
    reg_write(reg_cycles, $urandom);
    reg_read_check(reg_cycles, 32'd0, "reg_cycles");

    // running loop with random codes and durations.
    hi_code = 1 + ($urandom % 15);
    lo_code = $urandom % 16;
    while (lo_code == hi_code)
      lo_code = $urandom % 16;
    reg_write(reg_azmux, (hi_code << 4) | lo_code);
    reg_write(reg_sample, 1 + ($urandom % max_dur));
    reg_write(reg_precharge, 1 + ($urandom % max_dur));
    reg_write(reg_ctrl, 32'd1);
    reg_read_check(reg_ctrl, 32'd1, "reg_ctrl");
    wait_pulses(1'b0, 3);

    // new durations while running, landing just after a sample ends.
    wait_pulses(1'b1, 1);
    reg_write(reg_sample, 1 + ($urandom % max_dur));
    reg_write(reg_precharge, 1 + ($urandom % max_dur));
    wait_pulses(1'b0, 3);

    // stop mid-cycle, restart from pc boot and stop again.
    stop_and_hold();
    reg_write(reg_ctrl, 32'd1);
    wait_pulses(1'b0, 2);
    stop_and_hold();

    $display("checks %0d, errors %0d, signal strobes %0d, zero strobes %0d",
             check_count, error_count, pulses1, pulses0);
    if (error_count == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- rtl/az_frontend_top.sv
// top level joining the host register block to the auto-zero sequencer.
`timescale 1ns/1ps

module az_frontend_top #(
  parameter logic [az_pkg::duration_w-1:0]  default_sample    = 32'd400_000,
  parameter logic [az_pkg::precharge_w-1:0] default_precharge = 24'd10_000
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          reg_wr,
  input  logic [az_pkg::reg_addr_w-1:0] reg_addr,
  input  logic [az_pkg::reg_data_w-1:0] reg_wdata,
  output logic [az_pkg::reg_data_w-1:0] reg_rdata,
  output logic                          sw_pc_ctl,
  output logic [az_pkg::azmux_w-1:0]    azmux,
  output logic                          led0,
  output logic [az_pkg::monitor_w-1:0]  monitor,
  output logic                          sample_valid,
  output logic                          sample_phase
);
  import az_pkg::*;

  // register levels into the sequencer.
  logic                   run;
  logic [azmux_w-1:0]     azmux_lo_val;
  logic [azmux_w-1:0]     azmux_hi_val;
  logic [duration_w-1:0]  sample_duration;
  logic [precharge_w-1:0] precharge_duration;

  // end of loop pulse back to the cycle counter.
  logic cycle_done;

  // the reset defaults of the durations come from here.
  az_regs #(
    .default_sample    (default_sample),
    .default_precharge (default_precharge)
  ) u_regs (
    .clk                (clk),
    .reset              (reset),
    .reg_wr             (reg_wr),
    .reg_addr           (reg_addr),
    .reg_wdata          (reg_wdata),
    .cycle_done         (cycle_done),
    .reg_rdata          (reg_rdata),
    .run                (run),
    .azmux_lo_val       (azmux_lo_val),
    .azmux_hi_val       (azmux_hi_val),
    .sample_duration    (sample_duration),
    .precharge_duration (precharge_duration)
  );

  modulation_az u_mod (
    .clk                (clk),
    .reset              (reset),
    .run                (run),
    .azmux_lo_val       (azmux_lo_val),
    .azmux_hi_val       (azmux_hi_val),
    .sample_duration    (sample_duration),
    .precharge_duration (precharge_duration),
    .sw_pc_ctl          (sw_pc_ctl),
    .azmux              (azmux),
    .led0               (led0),
    .monitor            (monitor),
    .sample_valid       (sample_valid),
    .sample_phase       (sample_phase),
    .cycle_done         (cycle_done)
  );

endmodule

//--- rtl/az_pkg.sv
// sequencer state encoding, register map, field widths and switch levels for the az core.
package az_pkg;

  ////////////////////////////////
  // field widths.
  ////////////////////////////////

  // an azmux code selects one of the analog mux inputs.
  localparam int azmux_w = 4;

  // the sample duration is long enough to hold several seconds at 20 MHz.
  localparam int duration_w = 32;

  // pre-charge settling is short, so 24 bits is ample.
  localparam int precharge_w = 24;

  // width of the debug monitor bus.
  localparam int monitor_w = 8;

  // host register port.
  localparam int reg_addr_w = 3;
  localparam int reg_data_w = 32;

  ////////////////////////////////
  // register addresses.
  ////////////////////////////////

  localparam logic [reg_addr_w-1:0] reg_ctrl      = 3'd0;
  localparam logic [reg_addr_w-1:0] reg_azmux     = 3'd1;
  localparam logic [reg_addr_w-1:0] reg_sample    = 3'd2;
  localparam logic [reg_addr_w-1:0] reg_precharge = 3'd3;
  localparam logic [reg_addr_w-1:0] reg_cycles    = 3'd4;

  // pre-charge switch levels. boot protects the signal from mux charge injection.
  localparam logic sw_pc_signal = 1'b1;
  localparam logic sw_pc_boot   = 1'b0;

  // each timed phase has an entry state of one cycle followed by a wait state.
  typedef enum logic [3:0] {
    idle            = 4'd0,
    pc_boot_entry   = 4'd1,
    pc_boot_wait    = 4'd2,
    hi_entry        = 4'd3,
    hi_wait         = 4'd4,
    sig_entry       = 4'd5,
    sig_wait        = 4'd6,
    reprotect_entry = 4'd7,
    reprotect_wait  = 4'd8,
    lo_entry        = 4'd9,
    lo_wait         = 4'd10,
    loop_end        = 4'd11
  } az_state_t;

endpackage

//--- rtl/az_regs.sv
// host register block with run bit, azmux codes, phase durations and cycle counter readback.
`timescale 1ns/1ps

module az_regs #(
  parameter logic [az_pkg::duration_w-1:0]  default_sample    = 32'd400_000,
  parameter logic [az_pkg::precharge_w-1:0] default_precharge = 24'd10_000
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          reg_wr,
  input  logic [az_pkg::reg_addr_w-1:0] reg_addr,
  input  logic [az_pkg::reg_data_w-1:0] reg_wdata,
  input  logic                          cycle_done,
  output logic [az_pkg::reg_data_w-1:0] reg_rdata,
  output logic                          run,
  output logic [az_pkg::azmux_w-1:0]    azmux_lo_val,
  output logic [az_pkg::azmux_w-1:0]    azmux_hi_val,
  output logic [az_pkg::duration_w-1:0] sample_duration,
  output logic [az_pkg::precharge_w-1:0] precharge_duration
);
  import az_pkg::*;

  // count of completed modulation cycles, held at all ones once full.
  logic [reg_data_w-1:0] cycle_count;

  ////////////////////////////////
  // configuration writes.
  ////////////////////////////////

  // a write strobe lands here and the new value is seen by the sequencer one
  // cycle later.
  // the sequencer only picks values up at a phase entry, so a change made
  // mid-phase shows from the next phase that uses it.
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      run                <= 1'b0;
      azmux_lo_val       <= '0;
      azmux_hi_val       <= '0;
      sample_duration    <= default_sample;
      precharge_duration <= default_precharge;
    end
    else if (reg_wr)
    begin
      case (reg_addr)
        reg_ctrl:
          run <= reg_wdata[0];
        reg_azmux:
        begin
          // lo code in the low nibble, hi code above it.
          azmux_lo_val <= reg_wdata[azmux_w-1:0];
          azmux_hi_val <= reg_wdata[2*azmux_w-1:azmux_w];
        end
        reg_sample:
          sample_duration <= reg_wdata[duration_w-1:0];
        reg_precharge:
          precharge_duration <= reg_wdata[precharge_w-1:0];
        // the cycle count is read-only and other addresses are unmapped.
        default:
          run <= run;
      endcase
    end
  end

  ////////////////////////////////
  // completed cycle counter.
  ////////////////////////////////

  // one increment per loop_end pulse from the sequencer.
  // the count saturates rather than wrapping, so a long run never looks short.
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      cycle_count <= '0;
    end
    else if (cycle_done && (cycle_count != {reg_data_w{1'b1}}))
    begin
      cycle_count <= cycle_count + 1'b1;
    end
  end

  ////////////////////////////////
  // readback.
  ////////////////////////////////

  // reads are combinational from the address, so software can confirm every
  // setting and poll progress without a read strobe.
  always_comb
  begin
    case (reg_addr)
      reg_ctrl:
        reg_rdata = {{(reg_data_w-1){1'b0}}, run};
      reg_azmux:
        reg_rdata = {{(reg_data_w-2*azmux_w){1'b0}}, azmux_hi_val, azmux_lo_val};
      reg_sample:
        reg_rdata = sample_duration;
      reg_precharge:
        reg_rdata = {{(reg_data_w-precharge_w){1'b0}}, precharge_duration};
      reg_cycles:
        reg_rdata = cycle_count;
      // unmapped addresses read as zero.
      default:
        reg_rdata = '0;
    endcase
  end

endmodule

//--- rtl/modulation_az.sv
// auto-zero and pre-charge sequencer with phase down-counter, sample strobes, led and monitor.
`timescale 1ns/1ps

module modulation_az (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           run,
  input  logic [az_pkg::azmux_w-1:0]     azmux_lo_val,
  input  logic [az_pkg::azmux_w-1:0]     azmux_hi_val,
  input  logic [az_pkg::duration_w-1:0]  sample_duration,
  input  logic [az_pkg::precharge_w-1:0] precharge_duration,
  output logic                           sw_pc_ctl,
  output logic [az_pkg::azmux_w-1:0]     azmux,
  output logic                           led0,
  output logic [az_pkg::monitor_w-1:0]   monitor,
  output logic                           sample_valid,
  output logic                           sample_phase,
  output logic                           cycle_done
);
  import az_pkg::*;

  az_state_t state;
  az_state_t state_next;

  // phase down-counter, loaded in each entry state.
  logic [duration_w-1:0] count;
  logic                  count_zero;

  // pre-charge duration widened to the counter width.
  logic [duration_w-1:0] precharge_ext;

  // monitor flags, hi code selected and signal sample running.
  logic mon_hi;
  logic mon_sig;

  assign precharge_ext = {{(duration_w-precharge_w){1'b0}}, precharge_duration};
  assign count_zero    = (count == '0);

  ////////////////////////////////
  // next state.
  ////////////////////////////////

  // the pre-charge switching sits inside the azmux switching in time.
  // the signal is moved to boot before the mux leaves hi and only goes back
  // to signal once the mux is settled on hi again.
  // each wait leaves in the cycle its counter reads zero.
  always_comb
  begin
    state_next = state;
    case (state)
      idle:
        if (run)
          state_next = pc_boot_entry;
      pc_boot_entry:
        state_next = pc_boot_wait;
      pc_boot_wait:
        if (count_zero)
          state_next = hi_entry;
      hi_entry:
        state_next = hi_wait;
      hi_wait:
        if (count_zero)
          state_next = sig_entry;
      sig_entry:
        state_next = sig_wait;
      sig_wait:
        if (count_zero)
          state_next = reprotect_entry;
      reprotect_entry:
        state_next = reprotect_wait;
      reprotect_wait:
        if (count_zero)
          state_next = lo_entry;
      lo_entry:
        state_next = lo_wait;
      lo_wait:
        if (count_zero)
          state_next = loop_end;
      // run is only looked at here, so a started cycle always completes.
      loop_end:
        state_next = run ? hi_entry : idle;
      default:
        state_next = idle;
    endcase
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      state <= idle;
    else
      state <= state_next;
  end

  ////////////////////////////////
  // phase counter.
  ////////////////////////////////

  // a duration of d gives d+1 wait cycles, which with the entry cycle makes a
  // phase of d+2 cycles.
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      count <= '0;
    end
    else
    begin
      case (state)
        pc_boot_entry, hi_entry, reprotect_entry:
          count <= precharge_ext;
        sig_entry, lo_entry:
          count <= sample_duration;
        pc_boot_wait, hi_wait, sig_wait, reprotect_wait, lo_wait:
          if (!count_zero)
            count <= count - 1'b1;
        default:
          count <= count;
      endcase
    end
  end

  ////////////////////////////////
  // switch outputs.
  ////////////////////////////////

  // outputs change on the edge that enters a phase, decoded from the next state.
  // the azmux codes are picked up at that same edge.
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      sw_pc_ctl <= sw_pc_boot;
      azmux     <= '0;
      led0      <= 1'b0;
      mon_hi    <= 1'b0;
      mon_sig   <= 1'b0;
    end
    else if (state_next != state)
    begin
      case (state_next)
        // stopped. keep the signal protected.
        idle:
          sw_pc_ctl <= sw_pc_boot;
        pc_boot_entry:
        begin
          sw_pc_ctl <= sw_pc_boot;
          mon_hi    <= 1'b0;
          mon_sig   <= 1'b0;
        end
        // mux to the pre-charge output while it still holds boot.
        hi_entry:
        begin
          azmux  <= azmux_hi_val;
          mon_hi <= 1'b1;
        end
        // expose the signal and take the signal sample.
        sig_entry:
        begin
          sw_pc_ctl <= sw_pc_signal;
          led0      <= 1'b1;
          mon_sig   <= 1'b1;
        end
        // back to boot before the mux moves away, which ends the signal sample.
        reprotect_entry:
        begin
          sw_pc_ctl <= sw_pc_boot;
          led0      <= 1'b0;
          mon_sig   <= 1'b0;
        end
        // zero sample on the lo input.
        lo_entry:
        begin
          azmux  <= azmux_lo_val;
          mon_hi <= 1'b0;
        end
        default:
          sw_pc_ctl <= sw_pc_ctl;
      endcase
    end
  end

  ////////////////////////////////
  // strobes and monitor.
  ////////////////////////////////

  // a sample ends in the last wait cycle, just before the outputs change.
  assign sample_valid = count_zero && ((state == sig_wait) || (state == lo_wait));
  assign sample_phase = (state == sig_wait);
  assign cycle_done   = (state == loop_end);

  // bit 0 hi selected, bit 1 signal sample, bit 2 cycle done pulse.
  assign monitor = {{(monitor_w-3){1'b0}}, cycle_done, mon_sig, mon_hi};

endmodule

//--- tb.f
rtl/az_pkg.sv
rtl/az_regs.sv
rtl/modulation_az.sv
rtl/az_frontend_top.sv
bench/tb_az_frontend.sv
